//--- include/ntm_trainer_defines.svh
// Output-gate trainer constants
// Fixed-point widths, vector limits and the Wishbone register map
`ifndef NTM_TRAINER_DEFINES_SVH
`define NTM_TRAINER_DEFINES_SVH

// Signed Q8.8 data, 32-bit accumulators
`define NTM_DATA_W 16
`define NTM_FRAC_W 8
`define NTM_ACC_W  32

// Largest gate vector and input vector
`define NTM_MAX_L 4
`define NTM_MAX_X 4

////////////////////
// Word address map
////////////////////
`define NTM_ADR_CTRL   8'h00
`define NTM_ADR_STATUS 8'h01
`define NTM_ADR_SIZE   8'h02
// Input vectors, element index in the low 3 bits
`define NTM_ADR_DH     8'h10
`define NTM_ADR_T      8'h18
`define NTM_ADR_O      8'h20
`define NTM_ADR_X      8'h28
// Gradients, dW row-major by l then x
`define NTM_ADR_DW     8'h40
`define NTM_ADR_DB     8'h60

`endif

//--- source/ntm_pkg.sv
// Shared types of the output-gate trainer
// Fixed-point numbers, Wishbone request and response, size configuration
`include "ntm_trainer_defines.svh"

package ntm_pkg;

  // Q8.8 value and its wide accumulator
  typedef logic signed [`NTM_DATA_W-1:0] fixed_t;
  typedef logic signed [`NTM_ACC_W-1:0]  acc_t;

  // Host to slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [7:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  // Slave to host
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // Active counts, already clipped to the vector limits
  typedef struct packed {
    logic [2:0] l_size;
    logic [2:0] x_size;
  } size_cfg_t;

  // One element entering the delta pipeline
  typedef struct packed {
    fixed_t dh;
    fixed_t t;
    fixed_t o;
  } gate_in_t;

endpackage

//--- source/ntm_fixed_multiplier.sv
// Q8.8 multiplier, one register stage
// Full product, arithmetic shift by the fraction bits, saturation to 16 bits
`include "ntm_trainer_defines.svh"

module ntm_fixed_multiplier
  import ntm_pkg::*;
(
  input  logic   CLK,
  input  logic   RST,
  input  logic   in_valid,
  input  fixed_t a,
  input  fixed_t b,
  output logic   out_valid,
  output fixed_t product
);

  localparam int FULL_W = 2 * `NTM_DATA_W;
  localparam logic signed [FULL_W-1:0] SAT_MAX = (1 <<< (`NTM_DATA_W - 1)) - 1;
  localparam logic signed [FULL_W-1:0] SAT_MIN = -(1 <<< (`NTM_DATA_W - 1));

  logic signed [FULL_W-1:0] full_prod;
  logic signed [FULL_W-1:0] shifted;
  fixed_t                   sat_prod;

  // Multiply, rescale, clamp
  always_comb begin
    full_prod = a * b;
    shifted   = full_prod >>> `NTM_FRAC_W;
    if (shifted > SAT_MAX) begin
      sat_prod = fixed_t'(SAT_MAX);
    end else if (shifted < SAT_MIN) begin
      sat_prod = fixed_t'(SAT_MIN);
    end else begin
      sat_prod = shifted[`NTM_DATA_W-1:0];
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // Result only meaningful with out_valid
  always_ff @(posedge CLK) begin
    if (in_valid) begin
      product <= sat_prod;
    end
  end

  // Exactly one cycle of latency, so stages can chain
  a_latency : assert property (@(posedge CLK) disable iff (RST)
    out_valid == $past(in_valid));

endmodule

//--- source/ntm_output_delta.sv
// Output-gate delta pipeline
// do = dh * t * o * (1 - o), three chained multipliers, one element per cycle
// Element tag rides along, up to three elements in flight
`include "ntm_trainer_defines.svh"

module ntm_output_delta
  import ntm_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       in_valid,
  input  gate_in_t   operand,
  input  logic [1:0] in_tag,
  output logic       out_valid,
  output fixed_t     delta,
  output logic [1:0] out_tag
);

  // One in Q8.8
  localparam logic signed [`NTM_DATA_W:0] ONE_Q = 1 <<< `NTM_FRAC_W;
  localparam logic signed [`NTM_DATA_W:0] POS_MAX = (1 <<< (`NTM_DATA_W - 1)) - 1;

  logic       v1;
  logic       v2;
  fixed_t     p1;
  fixed_t     p2;
  fixed_t     o_d1;
  fixed_t     om_d2;
  logic [1:0] tag_d1;
  logic [1:0] tag_d2;

  logic signed [`NTM_DATA_W:0] om_wide;
  fixed_t                      om_sat;

  // 1 - o, only the top can overflow (o near -128)
  always_comb begin
    om_wide = ONE_Q - {o_d1[`NTM_DATA_W-1], o_d1};
    if (om_wide > POS_MAX) begin
      om_sat = fixed_t'(POS_MAX);
    end else begin
      om_sat = om_wide[`NTM_DATA_W-1:0];
    end
  end

  // Side delays lined up with the multiplier stages
  always_ff @(posedge CLK) begin
    o_d1    <= operand.o;
    om_d2   <= om_sat;
    tag_d1  <= in_tag;
    tag_d2  <= tag_d1;
    out_tag <= tag_d2;
  end

  ////////////////////
  // Stage 1  dh * t
  ////////////////////
  ntm_fixed_multiplier dh_t_mul (
    .CLK(CLK), .RST(RST),
    .in_valid (in_valid),
    .a        (operand.dh),
    .b        (operand.t),
    .out_valid(v1),
    .product  (p1)
  );

  // Stage 2  times o
  ntm_fixed_multiplier o_mul (
    .CLK(CLK), .RST(RST),
    .in_valid (v1),
    .a        (p1),
    .b        (o_d1),
    .out_valid(v2),
    .product  (p2)
  );

  // Stage 3  times (1 - o)
  ntm_fixed_multiplier om_mul (
    .CLK(CLK), .RST(RST),
    .in_valid (v2),
    .a        (p2),
    .b        (om_d2),
    .out_valid(out_valid),
    .product  (delta)
  );

endmodule

//--- source/ntm_vector_buffer.sv
// Vector memory as a register array
// One synchronous write port, two asynchronous read ports
// Element type chosen per instance, cleared to zero on reset
module ntm_vector_buffer #(
  parameter type elem_t = logic [15:0],
  parameter int  DEPTH  = 4
) (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  elem_t                    wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr_a,
  output elem_t                    rdata_a,
  input  logic [$clog2(DEPTH)-1:0] raddr_b,
  output elem_t                    rdata_b
);

  elem_t mem [DEPTH];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Reads see the array directly
  assign rdata_a = mem[raddr_a];
  assign rdata_b = mem[raddr_b];

  // Writers must keep to the real depth
  a_waddr_range : assert property (@(posedge CLK) disable iff (RST)
    we |-> (waddr < DEPTH));

endmodule

//--- source/ntm_wb_slave.sv
// Wishbone classic slave of the output-gate trainer
// Decodes the register map, holds the size register, pulses START and CLEAR,
// strobes input vector writes and returns gradient and status reads
// Ack follows a sampled request by one cycle
`include "ntm_trainer_defines.svh"

module ntm_wb_slave
  import ntm_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  // Host side
  input  wb_req_t   wb_req,
  output wb_rsp_t   wb_rsp,
  // Trainer control
  output logic      start,
  output logic      clear,
  output size_cfg_t size_cfg,
  input  logic      busy,
  // Input vector writes, bit order dh t o x
  output logic [3:0] in_we,
  output logic [$clog2((`NTM_MAX_L > `NTM_MAX_X) ? `NTM_MAX_L : `NTM_MAX_X)-1:0] in_idx,
  output fixed_t     in_data,
  // Gradient reads
  output logic [$clog2(`NTM_MAX_L * `NTM_MAX_X)-1:0] dw_raddr,
  input  acc_t                                       dw_rdata,
  output logic [$clog2(`NTM_MAX_L)-1:0]              db_raddr,
  input  acc_t                                       db_rdata
);

  localparam int IN_W  = $clog2((`NTM_MAX_L > `NTM_MAX_X) ? `NTM_MAX_L : `NTM_MAX_X);
  localparam int DW_N  = `NTM_MAX_L * `NTM_MAX_X;
  localparam int DW_AW = $clog2(DW_N);
  localparam int LW    = $clog2(`NTM_MAX_L);

  // Input blocks are 8 words apart
  localparam logic [4:0] DH_BLK = 5'(`NTM_ADR_DH >> 3);
  localparam logic [4:0] T_BLK  = 5'(`NTM_ADR_T >> 3);
  localparam logic [4:0] O_BLK  = 5'(`NTM_ADR_O >> 3);
  localparam logic [4:0] X_BLK  = 5'(`NTM_ADR_X >> 3);

  logic        ack_q;
  logic [31:0] rsp_dat;
  size_cfg_t   size_q;
  logic        req;
  logic        wr;
  logic [4:0]  blk;
  logic [2:0]  elem;
  logic [7:0]  dw_off;
  logic [7:0]  db_off;
  logic        dw_hit;
  logic        db_hit;
  logic [31:0] rdata;

  // 1-based count limited to the vector size, zero taken as one
  function automatic logic [2:0] clip_size(input logic [3:0] v, input int max_v);
    if (v == 4'd0) begin
      return 3'd1;
    end
    if (int'(v) > max_v) begin
      return 3'(max_v);
    end
    return v[2:0];
  endfunction

  // New request only while no ack is out
  assign req  = wb_req.cyc && wb_req.stb && !ack_q;
  assign wr   = req && wb_req.we;
  assign blk  = wb_req.adr[7:3];
  assign elem = wb_req.adr[2:0];

  ////////////////////
  // Write decode
  ////////////////////
  assign in_we[0] = wr && (blk == DH_BLK) && (elem < `NTM_MAX_L);
  assign in_we[1] = wr && (blk == T_BLK) && (elem < `NTM_MAX_L);
  assign in_we[2] = wr && (blk == O_BLK) && (elem < `NTM_MAX_L);
  assign in_we[3] = wr && (blk == X_BLK) && (elem < `NTM_MAX_X);
  assign in_idx   = IN_W'(elem);
  assign in_data  = fixed_t'(wb_req.dat[`NTM_DATA_W-1:0]);

  // Pulses; the trainer drops them while busy
  assign start = wr && (wb_req.adr == `NTM_ADR_CTRL) && wb_req.dat[0];
  assign clear = wr && (wb_req.adr == `NTM_ADR_CTRL) && wb_req.dat[1];

  ////////////////////
  // Read decode
  ////////////////////
  assign dw_off   = wb_req.adr - `NTM_ADR_DW;
  assign db_off   = wb_req.adr - `NTM_ADR_DB;
  assign dw_hit   = (wb_req.adr >= `NTM_ADR_DW) && (dw_off < DW_N);
  assign db_hit   = (wb_req.adr >= `NTM_ADR_DB) && (db_off < `NTM_MAX_L);
  assign dw_raddr = DW_AW'(dw_off);
  assign db_raddr = LW'(db_off);

  always_comb begin
    rdata = '0;
    if (wb_req.adr == `NTM_ADR_STATUS) begin
      rdata = {31'b0, busy};
    end else if (wb_req.adr == `NTM_ADR_SIZE) begin
      rdata = {24'b0, 1'b0, size_q.x_size, 1'b0, size_q.l_size};
    end else if (dw_hit) begin
      rdata = dw_rdata;
    end else if (db_hit) begin
      rdata = db_rdata;
    end
  end

  // Ack and size register, written at the ack edge
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ack_q  <= 1'b0;
      size_q <= '{l_size: 3'(`NTM_MAX_L), x_size: 3'(`NTM_MAX_X)};
    end else begin
      ack_q <= req;
      if (wr && (wb_req.adr == `NTM_ADR_SIZE)) begin
        size_q <= '{l_size: clip_size(wb_req.dat[3:0], `NTM_MAX_L),
                    x_size: clip_size(wb_req.dat[7:4], `NTM_MAX_X)};
      end
    end
  end

  // Read data held for the ack cycle
  always_ff @(posedge CLK) begin
    if (req) begin
      rsp_dat <= rdata;
    end
  end

  assign wb_rsp   = '{ack: ack_q, dat: rsp_dat};
  assign size_cfg = size_q;

  // Single-cycle ack even with the request still held
  a_ack_single : assert property (@(posedge CLK) disable iff (RST)
    wb_rsp.ack |=> !wb_rsp.ack);

endmodule

//--- source/ntm_output_trainer.sv
// Output-gate trainer control
// DELTA streams l through the delta pipeline, stores do and adds it into db
// PRODUCT streams every (l,x) pair, dW(l,x) += do(l) * x(x)
// CLEAR zeroes both gradient buffers, one entry per cycle
`include "ntm_trainer_defines.svh"

module ntm_output_trainer
  import ntm_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  // Control
  input  logic      start,
  input  logic      clear,
  input  size_cfg_t size_cfg,
  output logic      busy,
  // Input vector reads
  output logic [$clog2(`NTM_MAX_L)-1:0] dh_raddr,
  output logic [$clog2(`NTM_MAX_L)-1:0] t_raddr,
  output logic [$clog2(`NTM_MAX_L)-1:0] o_raddr,
  output logic [$clog2(`NTM_MAX_X)-1:0] x_raddr,
  input  fixed_t dh_val,
  input  fixed_t t_val,
  input  fixed_t o_val,
  input  fixed_t x_val,
  // dW read-modify-write
  output logic                                       dw_we,
  output logic [$clog2(`NTM_MAX_L * `NTM_MAX_X)-1:0] dw_waddr,
  output acc_t                                       dw_wdata,
  output logic [$clog2(`NTM_MAX_L * `NTM_MAX_X)-1:0] dw_raddr,
  input  acc_t                                       dw_cur,
  // db read-modify-write
  output logic                          db_we,
  output logic [$clog2(`NTM_MAX_L)-1:0] db_waddr,
  output acc_t                          db_wdata,
  output logic [$clog2(`NTM_MAX_L)-1:0] db_raddr,
  input  acc_t                          db_cur
);

  localparam int LW    = $clog2(`NTM_MAX_L);
  localparam int XW    = $clog2(`NTM_MAX_X);
  localparam int DW_N  = `NTM_MAX_L * `NTM_MAX_X;
  localparam int DW_AW = $clog2(DW_N);
  localparam logic [DW_AW-1:0] X_STRIDE = DW_AW'(`NTM_MAX_X);
  localparam logic [DW_AW-1:0] CLR_LAST = DW_AW'(DW_N - 1);

  typedef enum logic [1:0] {S_IDLE, S_DELTA, S_PRODUCT, S_CLEAR} state_t;

  state_t           state;
  size_cfg_t        cfg_q;
  logic             issuing;
  logic [LW-1:0]    cnt_l;
  logic [XW-1:0]    cnt_x;
  logic [DW_AW-1:0] clr_idx;
  logic [LW-1:0]    l_last;
  logic [XW-1:0]    x_last;

  // Delta path
  logic       dlt_in_valid;
  gate_in_t   dlt_operand;
  logic       dlt_valid;
  fixed_t     dlt_delta;
  logic [1:0] dlt_tag;
  fixed_t     do_mem [`NTM_MAX_L];

  // Product path
  logic             mul_in_valid;
  logic             mul_valid;
  fixed_t           mul_product;
  logic [DW_AW-1:0] prod_addr_q;

  // Accumulation rule, sign-extend then wrap at 32 bits
  function automatic acc_t acc_add(input acc_t acc, input fixed_t v);
    return acc + {{(`NTM_ACC_W - `NTM_DATA_W){v[`NTM_DATA_W-1]}}, v};
  endfunction

  // Sizes fixed for the whole run
  assign l_last = LW'(cfg_q.l_size - 3'd1);
  assign x_last = XW'(cfg_q.x_size - 3'd1);
  assign busy   = (state != S_IDLE);

  ////////////////////
  // Sequencer
  ////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= S_IDLE;
      cfg_q   <= '0;
      issuing <= 1'b0;
      cnt_l   <= '0;
      cnt_x   <= '0;
      clr_idx <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          cnt_l   <= '0;
          cnt_x   <= '0;
          clr_idx <= '0;
          // Clear wins when both bits are written
          if (clear) begin
            state <= S_CLEAR;
          end else if (start) begin
            state   <= S_DELTA;
            cfg_q   <= size_cfg;
            issuing <= 1'b1;
          end
        end
        S_DELTA: begin
          if (issuing) begin
            if (cnt_l == l_last) begin
              issuing <= 1'b0;
            end else begin
              cnt_l <= cnt_l + 1'b1;
            end
          end
          // Elements leave in order, the last tag closes the phase
          if (dlt_valid && (LW'(dlt_tag) == l_last)) begin
            state   <= S_PRODUCT;
            issuing <= 1'b1;
            cnt_l   <= '0;
          end
        end
        S_PRODUCT: begin
          if (issuing) begin
            if (cnt_x == x_last) begin
              cnt_x <= '0;
              if (cnt_l == l_last) begin
                issuing <= 1'b0;
              end else begin
                cnt_l <= cnt_l + 1'b1;
              end
            end else begin
              cnt_x <= cnt_x + 1'b1;
            end
          end
          // Last product back after the final issue
          if (!issuing && mul_valid) begin
            state <= S_IDLE;
          end
        end
        S_CLEAR: begin
          clr_idx <= clr_idx + 1'b1;
          if (clr_idx == CLR_LAST) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Local copy of do for the product phase
  always_ff @(posedge CLK) begin
    if (dlt_valid) begin
      do_mem[dlt_tag] <= dlt_delta;
    end
  end

  // dW address follows the multiplier by one cycle
  always_ff @(posedge CLK) begin
    prod_addr_q <= DW_AW'(cnt_l) * X_STRIDE + DW_AW'(cnt_x);
  end

  // Input reads
  assign dh_raddr = cnt_l;
  assign t_raddr  = cnt_l;
  assign o_raddr  = cnt_l;
  assign x_raddr  = cnt_x;

  assign dlt_in_valid = (state == S_DELTA) && issuing;
  assign dlt_operand  = '{dh: dh_val, t: t_val, o: o_val};
  assign mul_in_valid = (state == S_PRODUCT) && issuing;

  ntm_output_delta output_delta (
    .CLK(CLK), .RST(RST),
    .in_valid (dlt_in_valid),
    .operand  (dlt_operand),
    .in_tag   (2'(cnt_l)),
    .out_valid(dlt_valid),
    .delta    (dlt_delta),
    .out_tag  (dlt_tag)
  );

  ntm_fixed_multiplier product_mul (
    .CLK(CLK), .RST(RST),
    .in_valid (mul_in_valid),
    .a        (do_mem[cnt_l]),
    .b        (x_val),
    .out_valid(mul_valid),
    .product  (mul_product)
  );

  ////////////////////
  // Gradient writes
  ////////////////////
  assign dw_raddr = prod_addr_q;
  assign db_raddr = LW'(dlt_tag);

  always_comb begin
    dw_we    = 1'b0;
    dw_waddr = prod_addr_q;
    dw_wdata = acc_add(dw_cur, mul_product);
    db_we    = 1'b0;
    db_waddr = LW'(dlt_tag);
    db_wdata = acc_add(db_cur, dlt_delta);
    case (state)
      S_DELTA:   db_we = dlt_valid;
      S_PRODUCT: dw_we = mul_valid;
      S_CLEAR: begin
        dw_we    = 1'b1;
        dw_waddr = clr_idx;
        dw_wdata = '0;
        // db is shorter, covered by the first entries
        db_we    = (clr_idx < `NTM_MAX_L);
        db_waddr = LW'(clr_idx);
        db_wdata = '0;
      end
      default: ;
    endcase
  end

  // Work starts only on a request from the bus
  a_idle_exit : assert property (@(posedge CLK) disable iff (RST)
    (state == S_IDLE && !start && !clear) |=> (state == S_IDLE));

endmodule

//--- source/ntm_output_top.sv
// Output-gate trainer top level
// Wishbone slave, input and gradient vector buffers, trainer
`include "ntm_trainer_defines.svh"

module ntm_output_top
  import ntm_pkg::*;
(
  input  logic    CLK,
  input  logic    RST,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp
);

  localparam int LW    = $clog2(`NTM_MAX_L);
  localparam int XW    = $clog2(`NTM_MAX_X);
  localparam int IN_W  = $clog2((`NTM_MAX_L > `NTM_MAX_X) ? `NTM_MAX_L : `NTM_MAX_X);
  localparam int DW_N  = `NTM_MAX_L * `NTM_MAX_X;
  localparam int DW_AW = $clog2(DW_N);

  // Slave and trainer control
  logic      start;
  logic      clear;
  logic      busy;
  size_cfg_t size_cfg;

  // Bus writes into the input vectors
  logic [3:0]      in_we;
  logic [IN_W-1:0] in_idx;
  fixed_t          in_data;

  // Trainer reads of the input vectors
  logic [LW-1:0] dh_raddr;
  logic [LW-1:0] t_raddr;
  logic [LW-1:0] o_raddr;
  logic [XW-1:0] x_raddr;
  fixed_t        dh_val;
  fixed_t        t_val;
  fixed_t        o_val;
  fixed_t        x_val;

  // Gradient buffers, port a to the bus, port b to the trainer
  logic             dw_we;
  logic [DW_AW-1:0] dw_waddr;
  acc_t             dw_wdata;
  logic [DW_AW-1:0] dw_bus_raddr;
  acc_t             dw_bus_rdata;
  logic [DW_AW-1:0] dw_cur_raddr;
  acc_t             dw_cur;
  logic             db_we;
  logic [LW-1:0]    db_waddr;
  acc_t             db_wdata;
  logic [LW-1:0]    db_bus_raddr;
  acc_t             db_bus_rdata;
  logic [LW-1:0]    db_cur_raddr;
  acc_t             db_cur;

  ntm_wb_slave wb_slave (
    .CLK(CLK), .RST(RST),
    .wb_req(wb_req), .wb_rsp(wb_rsp),
    .start(start), .clear(clear), .size_cfg(size_cfg), .busy(busy),
    .in_we(in_we), .in_idx(in_idx), .in_data(in_data),
    .dw_raddr(dw_bus_raddr), .dw_rdata(dw_bus_rdata),
    .db_raddr(db_bus_raddr), .db_rdata(db_bus_rdata)
  );

  ////////////////////
  // Input vectors
  ////////////////////
  ntm_vector_buffer #(.elem_t(fixed_t), .DEPTH(`NTM_MAX_L)) dh_buffer (
    .CLK(CLK), .RST(RST),
    .we(in_we[0]), .waddr(in_idx[LW-1:0]), .wdata(in_data),
    .raddr_a(dh_raddr), .rdata_a(dh_val),
    .raddr_b('0), .rdata_b()
  );

  ntm_vector_buffer #(.elem_t(fixed_t), .DEPTH(`NTM_MAX_L)) t_buffer (
    .CLK(CLK), .RST(RST),
    .we(in_we[1]), .waddr(in_idx[LW-1:0]), .wdata(in_data),
    .raddr_a(t_raddr), .rdata_a(t_val),
    .raddr_b('0), .rdata_b()
  );

  ntm_vector_buffer #(.elem_t(fixed_t), .DEPTH(`NTM_MAX_L)) o_buffer (
    .CLK(CLK), .RST(RST),
    .we(in_we[2]), .waddr(in_idx[LW-1:0]), .wdata(in_data),
    .raddr_a(o_raddr), .rdata_a(o_val),
    .raddr_b('0), .rdata_b()
  );

  ntm_vector_buffer #(.elem_t(fixed_t), .DEPTH(`NTM_MAX_X)) x_buffer (
    .CLK(CLK), .RST(RST),
    .we(in_we[3]), .waddr(in_idx[XW-1:0]), .wdata(in_data),
    .raddr_a(x_raddr), .rdata_a(x_val),
    .raddr_b('0), .rdata_b()
  );

  ////////////////////
  // Gradients
  ////////////////////
  ntm_vector_buffer #(.elem_t(acc_t), .DEPTH(DW_N)) dw_buffer (
    .CLK(CLK), .RST(RST),
    .we(dw_we), .waddr(dw_waddr), .wdata(dw_wdata),
    .raddr_a(dw_bus_raddr), .rdata_a(dw_bus_rdata),
    .raddr_b(dw_cur_raddr), .rdata_b(dw_cur)
  );

  ntm_vector_buffer #(.elem_t(acc_t), .DEPTH(`NTM_MAX_L)) db_buffer (
    .CLK(CLK), .RST(RST),
    .we(db_we), .waddr(db_waddr), .wdata(db_wdata),
    .raddr_a(db_bus_raddr), .rdata_a(db_bus_rdata),
    .raddr_b(db_cur_raddr), .rdata_b(db_cur)
  );

  ntm_output_trainer output_trainer (
    .CLK(CLK), .RST(RST),
    .start(start), .clear(clear), .size_cfg(size_cfg), .busy(busy),
    .dh_raddr(dh_raddr), .t_raddr(t_raddr), .o_raddr(o_raddr), .x_raddr(x_raddr),
    .dh_val(dh_val), .t_val(t_val), .o_val(o_val), .x_val(x_val),
    .dw_we(dw_we), .dw_waddr(dw_waddr), .dw_wdata(dw_wdata),
    .dw_raddr(dw_cur_raddr), .dw_cur(dw_cur),
    .db_we(db_we), .db_waddr(db_waddr), .db_wdata(db_wdata),
    .db_raddr(db_cur_raddr), .db_cur(db_cur)
  );

endmodule

//--- sim/ntm_output_tb.sv
// Testbench of the output-gate trainer
// Wishbone host tasks, reference model of the Q8.8 rules, result checks
// and a cycle watchdog around the whole run
`include "ntm_trainer_defines.svh"

module ntm_output_tb
  import ntm_pkg::*;
();

  localparam int CYCLE_LIMIT = 20000;
  localparam int ACK_LIMIT   = 8;
  localparam int DW_N        = `NTM_MAX_L * `NTM_MAX_X;

  logic    CLK = 1'b0;
  logic    RST;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;

  int    cycle_count = 0;
  int    seed;
  string test_name;

  // Current step inputs and expected gradients
  fixed_t dh_v [`NTM_MAX_L];
  fixed_t t_v  [`NTM_MAX_L];
  fixed_t o_v  [`NTM_MAX_L];
  fixed_t x_v  [`NTM_MAX_X];
  acc_t   exp_dw [DW_N];
  acc_t   exp_db [`NTM_MAX_L];

  ntm_output_top ntm_output_top_i (.CLK(CLK), .RST(RST), .wb_req(wb_req), .wb_rsp(wb_rsp));

  always #20 CLK = ~CLK;

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  // Watchdog
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      stop_run("Run stopped, the cycle limit was reached before the tests finished");
    end
  end

  task automatic check_value(input string what, input acc_t expected, input acc_t actual);
    assert (actual === expected) else begin
      stop_run($sformatf("Error in %s: %s expected %0d, actual %0d",
                         test_name, what, expected, actual));
    end
  endtask

  ////////////////////
  // Bus host
  ////////////////////
  task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(posedge CLK);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdata};
    @(negedge CLK);
    while (!wb_rsp.ack) begin
      waited++;
      if (waited > ACK_LIMIT) begin
        stop_run("The slave never acknowledged a bus request");
      end
      @(negedge CLK);
    end
    rdata = wb_rsp.dat;
    @(posedge CLK);
    wb_req <= '0;
    // Exactly one ack per access
    @(negedge CLK);
    assert (!wb_rsp.ack) else stop_run("Ack stayed high for a second cycle");
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [31:0] wdata);
    logic [31:0] unused_rd;
    wb_access(1'b1, adr, wdata, unused_rd);
  endtask

  task automatic wb_read(input logic [7:0] adr, output logic [31:0] rdata);
    wb_access(1'b0, adr, 32'h0, rdata);
  endtask

  // Wait for BUSY to fall
  task automatic poll_idle();
    logic [31:0] st;
    st = 32'h1;
    while (st[0]) begin
      wb_read(`NTM_ADR_STATUS, st);
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////
  // Full product, shift by the fraction bits, clamp to 16 bits
  function automatic fixed_t q_mul(input fixed_t a, input fixed_t b);
    int p;
    p = (int'(a) * int'(b)) >>> `NTM_FRAC_W;
    if (p > 32767) p = 32767;
    if (p < -32768) p = -32768;
    return fixed_t'(p);
  endfunction

  function automatic fixed_t q_one_minus(input fixed_t o);
    int v;
    v = 256 - int'(o);
    if (v > 32767) v = 32767;
    return fixed_t'(v);
  endfunction

  task automatic model_step(input int l_n, input int x_n);
    fixed_t d;
    for (int l = 0; l < l_n; l++) begin
      d = q_mul(q_mul(q_mul(dh_v[l], t_v[l]), o_v[l]), q_one_minus(o_v[l]));
      // Signed cast extends d to the accumulator width
      // 32-bit sum wraps like the hardware accumulator
      exp_db[l] = exp_db[l] + acc_t'(d);
      for (int x = 0; x < x_n; x++) begin
        exp_dw[l * `NTM_MAX_X + x] = exp_dw[l * `NTM_MAX_X + x] + acc_t'(q_mul(d, x_v[x]));
      end
    end
  endtask

  ////////////////////
  // Test steps
  ////////////////////
  task automatic run_step(input int l_n, input int x_n, input bit saturate, input bit twice);
    logic [31:0] st;
    for (int i = 0; i < `NTM_MAX_L; i++) begin
      dh_v[i] = saturate ? (i[0] ? -16'sh8000 : 16'sh7fff) : fixed_t'($random(seed) % 1024);
      t_v[i]  = saturate ? 16'sh7fff : fixed_t'($random(seed) % 1024);
      o_v[i]  = saturate ? (i[1] ? 16'sh9000 : 16'sh7000) : fixed_t'($random(seed) % 512);
      x_v[i]  = fixed_t'($random(seed) % 1024);
      wb_write(`NTM_ADR_DH + 8'(i), {16'h0, dh_v[i]});
      wb_write(`NTM_ADR_T + 8'(i), {16'h0, t_v[i]});
      wb_write(`NTM_ADR_O + 8'(i), {16'h0, o_v[i]});
      wb_write(`NTM_ADR_X + 8'(i), {16'h0, x_v[i]});
    end
    wb_write(`NTM_ADR_SIZE, 32'((x_n << 4) | l_n));
    wb_write(`NTM_ADR_CTRL, 32'h1);
    // A second START lands while the first run is still going
    if (twice) begin
      wb_write(`NTM_ADR_CTRL, 32'h1);
      wb_read(`NTM_ADR_STATUS, st);
      check_value("STATUS after second START", 32'sd1, acc_t'(st));
    end
    poll_idle();
    model_step(l_n, x_n);
  endtask

  task automatic clear_all();
    wb_write(`NTM_ADR_CTRL, 32'h2);
    poll_idle();
    for (int i = 0; i < DW_N; i++) exp_dw[i] = '0;
    for (int l = 0; l < `NTM_MAX_L; l++) exp_db[l] = '0;
  endtask

  // Every gradient entry against the model
  task automatic check_all();
    logic [31:0] rd;
    for (int i = 0; i < DW_N; i++) begin
      wb_read(`NTM_ADR_DW + 8'(i), rd);
      check_value($sformatf("dW[%0d]", i), exp_dw[i], acc_t'(rd));
    end
    for (int l = 0; l < `NTM_MAX_L; l++) begin
      wb_read(`NTM_ADR_DB + 8'(l), rd);
      check_value($sformatf("db[%0d]", l), exp_db[l], acc_t'(rd));
    end
  endtask

  initial begin
    logic [31:0] st;
    seed   = 91772;
    RST    = 1'b1;
    wb_req = '0;
    for (int i = 0; i < DW_N; i++) exp_dw[i] = '0;
    for (int l = 0; l < `NTM_MAX_L; l++) exp_db[l] = '0;
    repeat (16) @(posedge CLK);
    RST <= 1'b0;

    test_name = "reset";
    wb_read(`NTM_ADR_STATUS, st);
    check_value("STATUS", 32'sd0, acc_t'(st));
    check_all();

    test_name = "single step";
    run_step(4, 4, 1'b0, 1'b0);
    check_all();

    test_name = "three steps";
    repeat (3) run_step(4, 4, 1'b0, 1'b0);
    check_all();

    test_name = "saturation";
    run_step(4, 4, 1'b1, 1'b0);
    check_all();

    test_name = "partial size";
    clear_all();
    run_step(2, 3, 1'b0, 1'b1);
    check_all();

    test_name = "clear";
    clear_all();
    check_all();
    run_step(4, 4, 1'b0, 1'b0);
    check_all();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- sources.f
+incdir+include
source/ntm_pkg.sv
source/ntm_fixed_multiplier.sv
source/ntm_output_delta.sv
source/ntm_vector_buffer.sv
source/ntm_wb_slave.sv
source/ntm_output_trainer.sv
source/ntm_output_top.sv
sim/ntm_output_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the output-gate trainer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ntm_output_tb -f sources.f -o ntm_output_sim

./obj_dir/ntm_output_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
  exit 1
fi
exit 0
